/* Makefile */
# Verilator build and run of the divide unit testbench

TOOL      ?= verilator
TOP       ?= divUnitTb
FILELIST  ?= divUnit.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES   := $(shell grep -v '^+' $(FILELIST))
DATA      := verif/divPatterns.hex
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST)

# The log decides the result, the simulator exit code alone is not trusted
run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/divIssueStage.sv */
// Issue stage with request capture register and operation decode
`timescale 1ns/10ps
`default_nettype none

module divIssueStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,            // Freezes the stage
    input  logic          reqValid,         // Single-cycle request strobe
    input  divPkg::DivReq req,
    output logic          issueValid,
    output divPkg::DivReq issueReq,
    output logic          isSigned,         // DIV and REM
    output logic          selectRemainder   // REM and REMU
);
    import divPkg::*;

    logic decSigned;     // Decoded from the incoming op
    logic decRemainder;
    logic capture;       // Request accepted this cycle

    assign capture = reqValid && !stall;

    // Operation decode ahead of the register
    always_comb begin
        decSigned    = 1'b0;
        decRemainder = 1'b0;
        case (req.op)
            DIV: begin
                decSigned = 1'b1;
            end
            DIVU: begin
                decSigned = 1'b0;  // Plain unsigned quotient
            end
            REM: begin
                decSigned    = 1'b1;
                decRemainder = 1'b1;
            end
            REMU: begin
                decRemainder = 1'b1;
            end
            default: begin
                decSigned    = 1'b0;
                decRemainder = 1'b0;
            end
        endcase
    end

    // Valid bit, bubble when no request
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issueValid <= 1'b0;
        end else if (!stall) begin
            issueValid <= reqValid;
        end
    end

    // Payload only loads on an accepted request
    always_ff @(posedge clk) begin
        if (capture) begin
            issueReq        <= req;
            isSigned        <= decSigned;
            selectRemainder <= decRemainder;
        end
    end

endmodule : divIssueStage

`default_nettype wire

/* design/divPkg.sv */
// Widths, operation enum and request, result and response structs of the divide unit
`default_nettype none

package divPkg;

    // Operand and result width
    parameter int DATA_WIDTH = 32;
    // Request tag width, returned unchanged with the result
    parameter int TAG_WIDTH = 4;

    typedef logic [DATA_WIDTH-1:0] DataPath;  // One operand or result word
    typedef logic [TAG_WIDTH-1:0]  DivTag;    // Request identifier

    // Encoding of the four divide operations
    typedef enum logic [1:0] {
        DIV  = 2'b00,  // Signed quotient
        DIVU = 2'b01,  // Unsigned quotient
        REM  = 2'b10,  // Signed remainder
        REMU = 2'b11   // Unsigned remainder
    } DivOp;

    // Request from the execute stage
    typedef struct packed {
        DivOp    op;
        DivTag   tag;
        DataPath dividend;
        DataPath divisor;
    } DivReq;

    // Divider output, both results kept until the result stage picks one
    typedef struct packed {
        logic    valid;
        DivTag   tag;
        logic    selectRemainder;  // Set for REM and REMU
        DataPath quotient;
        DataPath remainder;
    } DivResult;

    // Response word towards the core
    typedef struct packed {
        DivTag   tag;
        DataPath data;
    } DivResp;

endpackage : divPkg

`default_nettype wire

/* design/divResultStage.sv */
// Result stage selecting quotient or remainder into a registered tagged response
`timescale 1ns/10ps
`default_nettype none

module divResultStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stall,      // Holds the response
    input  divPkg::DivResult divResult,
    output logic             respValid,  // One pulse per result when not stalled
    output divPkg::DivResp   resp
);
    import divPkg::*;

    DataPath selData;  // Word chosen for this result
    logic    load;     // New result taken this cycle

    // Pick the word the op asked for
    assign selData = divResult.selectRemainder ? divResult.remainder
                                               : divResult.quotient;

    assign load = divResult.valid && !stall;

    // Valid follows the divider output
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            respValid <= 1'b0;
        end else if (!stall) begin
            respValid <= divResult.valid;
        end
    end

    // Response payload, kept while idle or stalled
    always_ff @(posedge clk) begin
        if (load) begin
            resp.tag  <= divResult.tag;
            resp.data <= selData;
        end
    end

endmodule : divResultStage

`default_nettype wire

/* design/divUnit.sv */
// Divide unit top level with issue stage, pipelined divider and result stage
`timescale 1ns/10ps
`default_nettype none

module divUnit #(
    parameter int PIPELINE_DEPTH = 3  // Divider register stages
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           stall,      // Global freeze of all stages
    input  logic           reqValid,
    input  divPkg::DivReq  req,
    output logic           respValid,
    output divPkg::DivResp resp
);
    import divPkg::*;

    // Issue stage outputs
    logic     issueValid;
    DivReq    issueReq;
    logic     isSigned;
    logic     selectRemainder;

    // Divider output
    DivResult divResult;

    // Request capture and decode, 1 cycle
    divIssueStage issue_i (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .reqValid        (reqValid),
        .req             (req),
        .issueValid      (issueValid),
        .issueReq        (issueReq),
        .isSigned        (isSigned),
        .selectRemainder (selectRemainder)
    );

    // Divide, PIPELINE_DEPTH cycles
    pipelinedDivider #(
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) divider_i (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .issueValid      (issueValid),
        .issueReq        (issueReq),
        .isSigned        (isSigned),
        .selectRemainder (selectRemainder),
        .divResult       (divResult)
    );

    // Result select and response register, 1 cycle
    divResultStage result_i (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .divResult (divResult),
        .respValid (respValid),
        .resp      (resp)
    );

endmodule : divUnit

`default_nettype wire

/* design/pipelinedDivider.sv */
// Combinational divide with special cases followed by a register pipeline of fixed depth
`timescale 1ns/10ps
`default_nettype none

module pipelinedDivider #(
    parameter int PIPELINE_DEPTH = 3  // Register stages, at least 1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             stall,           // Holds every stage
    input  logic             issueValid,
    input  divPkg::DivReq    issueReq,
    input  logic             isSigned,
    input  logic             selectRemainder,
    output divPkg::DivResult divResult        // From the last stage
);
    import divPkg::*;

    // Most negative signed value, overflows when divided by minus one
    localparam DataPath mostNegative = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam DataPath minusOne = '1;

    // Stage payload, the valid bit lives in its own reset vector
    typedef struct packed {
        DivTag   tag;
        logic    selectRemainder;
        DataPath quotient;
        DataPath remainder;
    } DivPayload;

    DivPayload nextPayload;                       // Result at the pipeline input
    DivPayload payloadPipe [PIPELINE_DEPTH];      // Data stages, no reset
    logic [PIPELINE_DEPTH-1:0] validPipe;         // Valid per stage

    DataPath dividend;
    DataPath divisor;
    logic    divByZero;
    logic    signedOverflow;

    assign dividend       = issueReq.dividend;
    assign divisor        = issueReq.divisor;
    assign divByZero      = (divisor == '0);
    assign signedOverflow = isSigned && (dividend == mostNegative) && (divisor == minusOne);

    // Full divide in one step, the pipeline only delays the result
    always_comb begin
        nextPayload.tag             = issueReq.tag;
        nextPayload.selectRemainder = selectRemainder;
        if (divByZero) begin
            nextPayload.quotient  = '1;        // All ones for both signednesses
            nextPayload.remainder = dividend;
        end else if (signedOverflow) begin
            nextPayload.quotient  = dividend;  // Wraps back to the dividend
            nextPayload.remainder = '0;
        end else if (isSigned) begin
            // Truncates toward zero, remainder follows the dividend sign
            nextPayload.quotient  = $signed(dividend) / $signed(divisor);
            nextPayload.remainder = $signed(dividend) % $signed(divisor);
        end else begin
            nextPayload.quotient  = dividend / divisor;
            nextPayload.remainder = dividend % divisor;
        end
    end

    // Valid bits shift with the data
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else if (!stall) begin
            validPipe[0] <= issueValid;
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // Payload shift register
    always_ff @(posedge clk) begin
        if (!stall) begin
            payloadPipe[0] <= nextPayload;
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                payloadPipe[i] <= payloadPipe[i-1];
            end
        end
    end

    // Last stage drives the result stage
    always_comb begin
        divResult.valid           = validPipe[PIPELINE_DEPTH-1];
        divResult.tag             = payloadPipe[PIPELINE_DEPTH-1].tag;
        divResult.selectRemainder = payloadPipe[PIPELINE_DEPTH-1].selectRemainder;
        divResult.quotient        = payloadPipe[PIPELINE_DEPTH-1].quotient;
        divResult.remainder       = payloadPipe[PIPELINE_DEPTH-1].remainder;
    end

endmodule : pipelinedDivider

`default_nettype wire

/* divUnit.f */
design/divPkg.sv
design/divIssueStage.sv
design/pipelinedDivider.sv
design/divResultStage.sv
design/divUnit.sv
verif/divUnitTb.sv

/* verif/divPatterns.hex */
// Columns: op tag dividend divisor expected, op 0 DIV 1 DIVU 2 REM 3 REMU
// One request per line, all values in hex
1 0 00000064 00000007 0000000e
3 1 00000064 00000007 00000002
1 2 ffffffff 00000001 ffffffff
3 3 ffffffff 00000010 0000000f
1 4 ffffffff 00000010 0fffffff
1 5 80000000 ffffffff 00000000
3 6 80000000 ffffffff 80000000
1 7 12345678 00001000 00012345
3 8 12345678 00001000 00000678
1 9 deadbeef 00010000 0000dead
3 a deadbeef 00010000 0000beef
1 b 00000000 00000005 00000000
1 c 000f4240 000003e8 000003e8
3 d 000f4243 000003e8 00000003
0 e fffffff9 00000002 fffffffd
2 f fffffff9 00000002 ffffffff
0 0 00000007 fffffffe fffffffd
2 1 00000007 fffffffe 00000001
0 2 fffffff9 fffffffe 00000003
2 3 fffffff9 fffffffe ffffffff
0 4 00000064 00000007 0000000e
2 5 00000064 00000007 00000002
0 6 ffffff9c 00000007 fffffff2
2 7 ffffff9c 00000007 fffffffe
0 8 80000000 00000002 c0000000
2 9 80000001 00000002 ffffffff
0 a 7fffffff ffffffff 80000001
0 b ffffffff 7fffffff 00000000
2 c ffffffff 7fffffff ffffffff
0 d 80000000 80000000 00000001
1 e 00001234 00000000 ffffffff
0 f ffffff9c 00000000 ffffffff
3 0 00001234 00000000 00001234
2 1 ffffff9c 00000000 ffffff9c
0 2 00000000 00000000 ffffffff
3 3 ffffffff 00000000 ffffffff
0 4 80000000 ffffffff 80000000
2 5 80000000 ffffffff 00000000
1 6 00000064 0000000a 0000000a
3 7 00000065 0000000a 00000001
0 8 fffffff6 00000003 fffffffd
2 9 fffffff6 00000003 ffffffff
1 a 00010000 00000100 00000100
2 b 7fffffff 00000010 0000000f

/* verif/divUnitTb.sv */
// Divide unit testbench with patterns, random gaps and stalls, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

module divUnitTb;
    import divPkg::*;

    localparam int PIPELINE_DEPTH  = 3;
    localparam int LATENCY         = PIPELINE_DEPTH + 2;  // Capture edge to sampled response
    localparam int NUM_PATTERNS    = 44;
    localparam int WORDS_PER_PAT   = 5;                   // op, tag, dividend, divisor, expected
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_GAP         = 3;                   // Idle cycles before a random request
    localparam int MAX_STALL       = 4;                   // Stall burst length
    localparam int PERIOD          = 100;                 // ns
    localparam int SEED            = 32'h22c01984;
    // Three passes over the patterns at worst-case spacing and doubled as margin
    localparam int WATCHDOG_CYCLES =
        (3 * NUM_PATTERNS * (MAX_GAP + MAX_STALL + LATENCY) + RESET_CYCLES) * 2 + 100;

    logic   clk;
    logic   rstN;
    logic   stall;
    logic   reqValid;
    DivReq  req;
    logic   respValid;
    DivResp resp;

    logic [31:0] patMem [0:NUM_PATTERNS*WORDS_PER_PAT-1];  // Raw pattern words

    DivResp expQ[$];   // Expected responses in request order
    int     edgeQ[$];  // Capture edge per queued request
    int     patQ[$];   // Pattern index, for messages

    int   edgeCount    = 0;
    int   checkCount   = 0;
    int   errorCount   = 0;
    int   issuedCount  = 0;
    int   sampledCount = 0;
    logic latencyOn    = 1'b1;  // Exact latency only holds without stalls

    divUnit #(
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .reqValid  (reqValid),
        .req       (req),
        .respValid (respValid),
        .resp      (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;  // Edge number for latency
    end

    // Request fields of one pattern line
    function automatic DivReq reqFromPattern(input int idx);
        DivReq r;
        int    base;
        base       = idx * WORDS_PER_PAT;
        r.op       = DivOp'(patMem[base][1:0]);
        r.tag      = patMem[base+1][TAG_WIDTH-1:0];
        r.dividend = patMem[base+2];
        r.divisor  = patMem[base+3];
        return r;
    endfunction

    // Tag and expected word of one pattern line
    function automatic DivResp respFromPattern(input int idx);
        DivResp r;
        int     base;
        base   = idx * WORDS_PER_PAT;
        r.tag  = patMem[base+1][TAG_WIDTH-1:0];
        r.data = patMem[base+4];
        return r;
    endfunction

    task automatic checkResp(input string name, input DivResp got, input DivResp exp,
                             input int idx);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %s (pattern %0d): tag %h data %h, expected tag %h data %h",
                     name, idx, got.tag, got.data, exp.tag, exp.data);
        end
    endtask

    task automatic checkIdle(input string name, input logic got);
        checkCount++;
        if (got !== 1'b0) begin
            errorCount++;
            $display("FAILED %s: got %h, expected 0 with no result due", name, got);
        end
    endtask

    task automatic checkLatency(input int got, input int idx);
        checkCount++;
        if (got != LATENCY) begin
            errorCount++;
            $display("Response for pattern %0d came %0d cycles after capture instead of %0d",
                     idx, got, LATENCY);
        end
    endtask

    // Consumer samples mid-cycle where outputs are settled
    always @(negedge clk) begin : monitor
        DivResp expResp;
        int     capEdge;
        int     idx;
        if (respValid && !stall) begin
            sampledCount++;  // Every response taken at the coming edge
        end
        if (expQ.size() == 0) begin
            checkIdle("respValid", respValid);  // Nothing in flight
        end else if (respValid && !stall) begin
            expResp = expQ.pop_front();
            capEdge = edgeQ.pop_front();
            idx     = patQ.pop_front();
            checkResp("resp", resp, expResp, idx);
            if (latencyOn) begin
                checkLatency(edgeCount + 1 - capEdge, idx);
            end
        end
    end

    // Inputs for one cycle set just after the rising edge
    task automatic driveCycle(input logic valid, input DivReq r, input logic st, input int idx);
        @(posedge clk);
        #1;
        reqValid = valid;
        req      = r;
        stall    = st;
        if (valid && !st) begin
            expQ.push_back(respFromPattern(idx));
            edgeQ.push_back(edgeCount + 1);  // Captured at the next edge
            patQ.push_back(idx);
            issuedCount++;
        end
    endtask

    task automatic runResetTest();
        int checksAtStart;
        int errorsAtStart;
        checksAtStart = checkCount;
        errorsAtStart = errorCount;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (4) @(posedge clk);  // Quiet after release while the monitor watches respValid
        #1;
        $display("Test 1 reset: %0d checks, %0d errors",
                 checkCount - checksAtStart, errorCount - errorsAtStart);
    endtask

    task automatic runPatterns(input int testNum, input string name, input int first,
                               input int last, input logic randomMode);
        int    checksAtStart;
        int    errorsAtStart;
        int    issuedAtStart;
        int    sampledAtStart;
        int    gap;
        int    stallLen;
        DivReq idleReq;
        checksAtStart  = checkCount;
        errorsAtStart  = errorCount;
        issuedAtStart  = issuedCount;
        sampledAtStart = sampledCount;
        idleReq        = '0;
        latencyOn      = !randomMode;
        for (int i = first; i <= last; i++) begin
            if (randomMode) begin
                gap      = $urandom_range(MAX_GAP, 0);
                stallLen = ($urandom_range(1, 0) == 1) ? $urandom_range(MAX_STALL, 1) : 0;
                repeat (gap) driveCycle(1'b0, idleReq, 1'b0, 0);
                repeat (stallLen) driveCycle(1'b0, idleReq, 1'b1, 0);  // Freeze in flight
            end
            driveCycle(1'b1, reqFromPattern(i), 1'b0, i);
        end
        while (expQ.size() != 0) begin  // Drain until every response is back
            driveCycle(1'b0, idleReq, randomMode && ($urandom_range(3, 0) == 0), 0);
        end
        repeat (3) driveCycle(1'b0, idleReq, 1'b0, 0);  // No stray response afterwards
        if (sampledCount - sampledAtStart != issuedCount - issuedAtStart) begin
            errorCount++;
            $display("Test %0d sampled %0d responses for %0d requests", testNum,
                     sampledCount - sampledAtStart, issuedCount - issuedAtStart);
        end
        $display("Test %0d %s: %0d requests, %0d checks, %0d errors", testNum, name,
                 issuedCount - issuedAtStart, checkCount - checksAtStart,
                 errorCount - errorsAtStart);
    endtask

    initial begin
        rstN     = 1'b0;
        stall    = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        void'($urandom(SEED));
        $readmemh("verif/divPatterns.hex", patMem);
        runResetTest();
        runPatterns(2, "unsigned DIVU and REMU", 0, 13, 1'b0);
        runPatterns(3, "signed DIV and REM", 14, 29, 1'b0);
        runPatterns(4, "divide by zero and overflow", 30, 37, 1'b0);
        runPatterns(5, "back-to-back stream", 0, NUM_PATTERNS - 1, 1'b0);
        runPatterns(6, "random gaps and stalls", 0, NUM_PATTERNS - 1, 1'b1);
        $display("Summary: 6 tests, %0d requests, %0d checks, %0d errors",
                 issuedCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, a response never arrived",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : divUnitTb

`default_nettype wire
